// ==== fx_defines.svh ====
`ifndef FX_DEFINES_SVH
`define FX_DEFINES_SVH

// Q8.8 number format
`define FX_WIDTH 16
`define FX_FRAC 8

// iteration counts of the sequential units
`define FX_DIV_STEPS 23  // quotient width, width + frac - 1
`define FX_MUL_STEPS 16  // one step per multiplier bit

`endif

// ==== fx_num_pkg.sv ====
`include "fx_defines.svh"

package fx_num_pkg;

    // signed Q8.8 word
    typedef logic signed [`FX_WIDTH-1:0] fx_word_t;

    // unsigned magnitude, holds 0x8000 for the most negative word
    typedef logic [`FX_WIDTH-1:0] fx_mag_t;

    // full product of two magnitudes
    typedef logic [2*`FX_WIDTH-1:0] fx_prod_t;

endpackage

// ==== fx_op_pkg.sv ====
package fx_op_pkg;

    // command opcode
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2,
        op_div = 2'd3
    } fx_op_e;

    // control state, also selects the unit that owns the operation
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_mul  = 2'd1,  // waiting on multiplier
        st_div  = 2'd2,  // waiting on divider
        st_done = 2'd3   // single cycle ops and divide by zero
    } fx_state_e;

endpackage

// ==== fx_adder.sv ====
`timescale 1ns/1ps

module fx_adder #(
    parameter int width = 16
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             is_subtract,
    output logic [width-1:0] result,
    output logic             overflow_flag,
    output logic             carry,
    output logic             negative
);

    logic [width-1:0] b_eff;
    logic [width:0]   c;

    assign b_eff = is_subtract ? ~b : b;  // invert, carry in adds the one

    always_comb begin
        c[0] = is_subtract;
        for (int i = 0; i < width; i++) begin
            result[i] = a[i] ^ b_eff[i] ^ c[i];
            c[i+1]    = (a[i] & b_eff[i]) | (c[i] & (a[i] ^ b_eff[i]));
        end
    end

    assign carry         = c[width];
    assign overflow_flag = c[width] ^ c[width-1];  // carry into and out of msb differ
    assign negative      = result[width-1];

endmodule

// ==== fx_multiplier.sv ====
`timescale 1ns/1ps
`include "fx_defines.svh"

module fx_multiplier (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  fx_num_pkg::fx_mag_t multiplicand,
    input  fx_num_pkg::fx_mag_t multiplier,
    output fx_num_pkg::fx_mag_t product,
    output logic                overflow,
    output logic                finish
);

    localparam logic [4:0] last_step = 5'(`FX_MUL_STEPS);

    fx_num_pkg::fx_prod_t acc;  // {partial sum, remaining multiplier bits}
    fx_num_pkg::fx_mag_t  mcand;
    logic                 working;
    logic [4:0]           count;
    logic [4:0]           count_next;
    logic [23:0]          hi_sum;

    fx_adder #(.width(24)) u_acc_add (
        .a({8'b0, acc[31:16]}),
        .b({8'b0, (acc[0] ? mcand : 16'b0)}),  // add only on a set bit
        .is_subtract(1'b0),
        .result(hi_sum),
        .overflow_flag(),
        .carry(),
        .negative()
    );

    fx_adder #(.width(5)) u_count_add (
        .a(count),
        .b(5'd1),
        .is_subtract(1'b0),
        .result(count_next),
        .overflow_flag(),
        .carry(),
        .negative()
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            working <= 1'b0;
            finish  <= 1'b0;
            count   <= '0;
        end else if (start) begin
            working <= 1'b1;
            finish  <= 1'b0;
            count   <= '0;
        end else if (working) begin
            count   <= count_next;
            finish  <= (count_next == last_step);
            working <= (count_next != last_step);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc   <= {16'b0, multiplier};
            mcand <= multiplicand;
        end else if (working) begin
            acc <= {hi_sum[16:0], acc[15:1]};  // sum carry enters at the top
        end
    end

    assign product  = acc[`FX_FRAC +: `FX_WIDTH];
    assign overflow = |acc[31:23];  // shifted product above 0x7fff

endmodule

// ==== fx_divider.sv ====
`timescale 1ns/1ps
`include "fx_defines.svh"

module fx_divider (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  fx_num_pkg::fx_mag_t dividend,
    input  fx_num_pkg::fx_mag_t divisor,
    output fx_num_pkg::fx_mag_t quotient,
    output logic                overflow,
    output logic                finish
);

    localparam int         rem_w     = 2 * `FX_DIV_STEPS;
    localparam logic [4:0] last_step = 5'(`FX_DIV_STEPS);

    logic [rem_w-1:0]    rem;  // remainder in [45:23], quotient bits below
    fx_num_pkg::fx_mag_t dvs;
    logic                sub_op;
    logic                q_top;  // quotient bit 23
    logic                unit_top;
    logic                working;
    logic [4:0]          count;
    logic [4:0]          count_next;
    logic [23:0]         part;

    // the dividend msb alone can only reach a divisor of one, so that
    // first quotient bit is settled at load and the loop runs 23 steps
    assign unit_top = dividend[15] & (divisor == 16'd1);

    fx_adder #(.width(24)) u_rem_add (
        .a({1'b0, rem[45:23]}),
        .b({8'b0, dvs}),
        .is_subtract(sub_op),
        .result(part),
        .overflow_flag(),
        .carry(),
        .negative()
    );

    fx_adder #(.width(5)) u_count_add (
        .a(count),
        .b(5'd1),
        .is_subtract(1'b0),
        .result(count_next),
        .overflow_flag(),
        .carry(),
        .negative()
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            working <= 1'b0;
            finish  <= 1'b0;
            count   <= '0;
        end else if (start) begin
            working <= 1'b1;
            finish  <= 1'b0;
            count   <= '0;
        end else if (working) begin
            count   <= count_next;
            finish  <= (count_next == last_step);
            working <= (count_next != last_step);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            // dividend << FX_FRAC, one position up with bit 23 consumed
            rem    <= {21'b0, dividend[15] & ~unit_top, dividend[14:0],
                       {(`FX_FRAC + 1){1'b0}}};
            dvs    <= divisor;
            q_top  <= unit_top;
            sub_op <= 1'b1;  // remainder starts non-negative
        end else if (working) begin
            rem    <= {part[21:0], rem[22:0], ~part[22]};  // shift in next bit
            sub_op <= ~part[22];
        end
    end

    assign quotient = rem[15:0];
    assign overflow = q_top | (|rem[22:15]);  // does not fit a positive word

endmodule

// ==== fx_control.sv ====
`timescale 1ns/1ps
`include "fx_defines.svh"

module fx_control (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  fx_op_pkg::fx_op_e    cmd_op,
    input  fx_num_pkg::fx_word_t operand_a,
    input  fx_num_pkg::fx_word_t operand_b,
    output logic                 mul_start,
    output logic                 div_start,
    output fx_num_pkg::fx_mag_t  mag_a,
    output fx_num_pkg::fx_mag_t  mag_b,
    input  fx_num_pkg::fx_mag_t  mul_product,
    input  logic                 mul_overflow,
    input  logic                 mul_finish,
    input  fx_num_pkg::fx_mag_t  div_quotient,
    input  logic                 div_overflow,
    input  logic                 div_finish,
    output fx_num_pkg::fx_word_t result,
    output logic                 overflow,
    output logic                 div_by_zero,
    output logic                 done,
    output logic                 busy
);

    fx_op_pkg::fx_state_e state;
    fx_op_pkg::fx_op_e    op_q;
    fx_num_pkg::fx_word_t a_q;
    fx_num_pkg::fx_word_t b_q;
    fx_num_pkg::fx_word_t sum;
    logic                 sum_ovf;
    logic                 neg_q;  // result sign for mul and div
    logic                 accept;

    function automatic fx_num_pkg::fx_mag_t magnitude(input fx_num_pkg::fx_word_t v);
        return v[`FX_WIDTH-1] ? fx_num_pkg::fx_mag_t'(-v) : fx_num_pkg::fx_mag_t'(v);
    endfunction

    function automatic fx_num_pkg::fx_word_t apply_sign(input fx_num_pkg::fx_mag_t mag,
                                                        input logic neg);
        fx_num_pkg::fx_mag_t tmp;
        tmp = neg ? (~mag + 1'b1) : mag;
        return fx_num_pkg::fx_word_t'(tmp);
    endfunction

    fx_adder #(.width(`FX_WIDTH)) u_add (
        .a(a_q),
        .b(b_q),
        .is_subtract(op_q == fx_op_pkg::op_sub),
        .result(sum),
        .overflow_flag(sum_ovf),
        .carry(),
        .negative()
    );

    assign accept = (state == fx_op_pkg::st_idle) && cmd_valid && !busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= cmd_op;
            a_q   <= operand_a;
            b_q   <= operand_b;
            mag_a <= magnitude(operand_a);
            mag_b <= magnitude(operand_b);
            neg_q <= operand_a[`FX_WIDTH-1] ^ operand_b[`FX_WIDTH-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= fx_op_pkg::st_idle;
            busy        <= 1'b0;
            done        <= 1'b0;
            mul_start   <= 1'b0;
            div_start   <= 1'b0;
            result      <= '0;
            overflow    <= 1'b0;
            div_by_zero <= 1'b0;
        end else begin
            done      <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            case (state)
                fx_op_pkg::st_idle: begin
                    busy <= accept;  // drops the cycle after done
                    if (accept) begin
                        if (cmd_op == fx_op_pkg::op_mul) begin
                            mul_start <= 1'b1;
                            state     <= fx_op_pkg::st_mul;
                        end else if (cmd_op == fx_op_pkg::op_div && operand_b != '0) begin
                            div_start <= 1'b1;
                            state     <= fx_op_pkg::st_div;
                        end else begin
                            state <= fx_op_pkg::st_done;
                        end
                    end
                end
                fx_op_pkg::st_done: begin
                    div_by_zero <= (op_q == fx_op_pkg::op_div);
                    result      <= (op_q == fx_op_pkg::op_div) ? '0 : sum;
                    overflow    <= (op_q != fx_op_pkg::op_div) && sum_ovf;
                    done        <= 1'b1;
                    state       <= fx_op_pkg::st_idle;
                end
                // finish still shows the last run while start is out
                fx_op_pkg::st_mul: begin
                    if (mul_finish && !mul_start) begin
                        result      <= apply_sign(mul_product, neg_q);
                        overflow    <= mul_overflow;
                        div_by_zero <= 1'b0;
                        done        <= 1'b1;
                        state       <= fx_op_pkg::st_idle;
                    end
                end
                fx_op_pkg::st_div: begin
                    if (div_finish && !div_start) begin
                        result      <= apply_sign(div_quotient, neg_q);
                        overflow    <= div_overflow;
                        div_by_zero <= 1'b0;
                        done        <= 1'b1;
                        state       <= fx_op_pkg::st_idle;
                    end
                end
                default: state <= fx_op_pkg::st_idle;
            endcase
        end
    end

endmodule

// ==== fx_unit_top.sv ====
`timescale 1ns/1ps

module fx_unit_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  fx_op_pkg::fx_op_e    cmd_op,
    input  fx_num_pkg::fx_word_t operand_a,
    input  fx_num_pkg::fx_word_t operand_b,
    output fx_num_pkg::fx_word_t result,
    output logic                 overflow,
    output logic                 div_by_zero,
    output logic                 done,
    output logic                 busy
);

    logic                mul_start;
    logic                div_start;
    fx_num_pkg::fx_mag_t mag_a;
    fx_num_pkg::fx_mag_t mag_b;
    fx_num_pkg::fx_mag_t mul_product;
    logic                mul_overflow;
    logic                mul_finish;
    fx_num_pkg::fx_mag_t div_quotient;
    logic                div_overflow;
    logic                div_finish;

    fx_control u_control (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_op(cmd_op),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .mul_start(mul_start),
        .div_start(div_start),
        .mag_a(mag_a),
        .mag_b(mag_b),
        .mul_product(mul_product),
        .mul_overflow(mul_overflow),
        .mul_finish(mul_finish),
        .div_quotient(div_quotient),
        .div_overflow(div_overflow),
        .div_finish(div_finish),
        .result(result),
        .overflow(overflow),
        .div_by_zero(div_by_zero),
        .done(done),
        .busy(busy)
    );

    fx_multiplier u_mul (
        .clk(clk),
        .rst(rst),
        .start(mul_start),
        .multiplicand(mag_a),
        .multiplier(mag_b),
        .product(mul_product),
        .overflow(mul_overflow),
        .finish(mul_finish)
    );

    fx_divider u_div (
        .clk(clk),
        .rst(rst),
        .start(div_start),
        .dividend(mag_a),
        .divisor(mag_b),
        .quotient(div_quotient),
        .overflow(div_overflow),
        .finish(div_finish)
    );

endmodule

// ==== tb_fx_unit.sv ====
`timescale 1ns/1ps
`include "fx_defines.svh"

module tb_fx_unit;

    logic                 clk;
    logic                 rst;
    logic                 cmd_valid;
    fx_op_pkg::fx_op_e    cmd_op;
    fx_num_pkg::fx_word_t operand_a;
    fx_num_pkg::fx_word_t operand_b;
    fx_num_pkg::fx_word_t result;
    logic                 overflow;
    logic                 div_by_zero;
    logic                 done;
    logic                 busy;

    integer seed;
    int     cyc = 0;
    int     errors = 0;
    int     timeouts = 0;
    int     issued = 0;
    int     checked = 0;

    // one entry per command in issue order
    logic [17:0] exp_q[$];  // {div_by_zero, overflow, result}
    int          lat_q[$];
    int          issue_q[$];
    logic [33:0] cmd_q[$];  // {op, a, b}

    fx_unit_top dut (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_op(cmd_op),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .result(result),
        .overflow(overflow),
        .div_by_zero(div_by_zero),
        .done(done),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [17:0] fx_model(input logic [1:0] op, input logic [15:0] a,
                                             input logic [15:0] b);
        logic [15:0] r;
        logic        ovf;
        logic        dbz;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        ma  = {16'b0, (a[15] ? 16'h0 - a : a)};
        mb  = {16'b0, (b[15] ? 16'h0 - b : b)};
        r   = 16'h0;
        ovf = 1'b0;
        dbz = 1'b0;
        q   = 32'b0;
        case (op)
            2'd0: begin
                r   = a + b;
                ovf = (a[15] == b[15]) && (r[15] != a[15]);
            end
            2'd1: begin
                r   = a - b;
                ovf = (a[15] != b[15]) && (r[15] != a[15]);
            end
            2'd2: q = (ma * mb) >> `FX_FRAC;
            default: begin
                if (mb == 32'b0) begin
                    dbz = 1'b1;
                end else begin
                    q = (ma << `FX_FRAC) / mb;
                end
            end
        endcase
        if (op[1]) begin
            ovf = (q >= 32'h8000);  // magnitude beyond a positive word
            r   = (a[15] ^ b[15]) ? 16'h0 - q[15:0] : q[15:0];
        end
        return {dbz, ovf, r};
    endfunction

    function automatic int latency_of(input logic [1:0] op, input logic [15:0] b);
        if (op == 2'd2) return `FX_MUL_STEPS + 2;
        if (op == 2'd3 && b != 16'h0) return `FX_DIV_STEPS + 2;
        return 1;
    endfunction

    // mostly full range with some small values and zeros
    function automatic logic [15:0] pick_operand(input logic [31:0] r);
        if (r[19:16] == 4'd0) return 16'h0;
        if (r[19:16] < 4'd6) return {{6{r[9]}}, r[9:0]};
        return r[15:0];
    endfunction

    task automatic send_cmd(input logic [1:0] op, input logic [15:0] a, input logic [15:0] b);
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            timeouts++;
            $display("timeout: busy never dropped before op %0d", op);
        end
        cmd_valid = 1'b1;
        cmd_op    = fx_op_pkg::fx_op_e'(op);
        operand_a = a;
        operand_b = b;
        exp_q.push_back(fx_model(op, a, b));
        lat_q.push_back(latency_of(op, b));
        issue_q.push_back(cyc);
        cmd_q.push_back({op, a, b});
        issued++;
        @(negedge clk);
        cmd_valid = 1'b0;
        if (busy !== 1'b1) begin
            errors++;
            $display("error: busy after accept expected 1 got %h (op %0d)", busy, op);
        end
    endtask

    task automatic wait_result();
        int waited;
        waited = 0;
        while (checked != issued && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (checked != issued) begin
            timeouts++;
            $display("timeout: command %0d was never checked", issued);
        end
    endtask

    task automatic run_cmd(input logic [1:0] op, input logic [15:0] a, input logic [15:0] b);
        send_cmd(op, a, b);
        wait_result();
    endtask

    initial begin : compare
        logic [17:0] want;
        logic [33:0] info;
        int          lat;
        int          start;
        int          waited;
        forever begin
            @(negedge clk);
            if (exp_q.size() == 0) begin
                if (done === 1'b1) begin
                    errors++;
                    $display("done pulsed with no command pending at cycle %0d", cyc);
                end
            end else begin
                waited = 0;
                while (done !== 1'b1 && waited < 100) begin
                    @(negedge clk);
                    waited++;
                end
                want  = exp_q.pop_front();
                lat   = lat_q.pop_front();
                start = issue_q.pop_front();
                info  = cmd_q.pop_front();
                if (done !== 1'b1) begin
                    timeouts++;
                    $display("timeout: done never came for op %0d a %h b %h",
                             info[33:32], info[31:16], info[15:0]);
                end else begin
                    if (result !== want[15:0]) begin
                        errors++;
                        $display("error: result expected %h got %h (op %0d a %h b %h)",
                                 want[15:0], result, info[33:32], info[31:16], info[15:0]);
                    end
                    if (overflow !== want[16]) begin
                        errors++;
                        $display("error: overflow expected %h got %h (op %0d a %h b %h)",
                                 want[16], overflow, info[33:32], info[31:16], info[15:0]);
                    end
                    if (div_by_zero !== want[17]) begin
                        errors++;
                        $display("error: div_by_zero expected %h got %h (op %0d a %h b %h)",
                                 want[17], div_by_zero, info[33:32], info[31:16], info[15:0]);
                    end
                    if (busy !== 1'b1) begin
                        errors++;
                        $display("error: busy at done expected 1 got %h (op %0d)",
                                 busy, info[33:32]);
                    end
                    if (cyc - start - 1 != lat) begin
                        errors++;
                        $display("done came %0d cycles after the command instead of %0d (op %0d)",
                                 cyc - start - 1, lat, info[33:32]);
                    end
                end
                checked++;
            end
        end
    end

    initial begin
        logic [17:0] held;
        logic [31:0] rnd;
        logic [31:0] ra;
        logic [31:0] rb;
        seed      = 32'h3cf9_af30;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = fx_op_pkg::op_add;
        operand_a = '0;
        operand_b = '0;
        repeat (10) @(negedge clk);
        if (done !== 1'b0 || busy !== 1'b0) begin
            errors++;
            $display("error: done/busy after reset expected 0/0 got %h/%h", done, busy);
        end
        if (overflow !== 1'b0 || div_by_zero !== 1'b0) begin
            errors++;
            $display("error: overflow/div_by_zero after reset expected 0/0 got %h/%h",
                     overflow, div_by_zero);
        end
        if (result !== 16'h0) begin
            errors++;
            $display("error: result after reset expected 0000 got %h", result);
        end
        rst = 1'b0;

        run_cmd(2'd0, 16'h0180, 16'h0240);
        run_cmd(2'd0, 16'h7000, 16'h2000);  // positive wrap
        run_cmd(2'd0, 16'h8000, 16'hff00);  // negative wrap
        run_cmd(2'd1, 16'h0100, 16'h0300);
        run_cmd(2'd1, 16'h8000, 16'h0100);
        run_cmd(2'd1, 16'h7fff, 16'hffff);

        run_cmd(2'd2, 16'h0080, 16'h0080);  // 0.5 * 0.5
        run_cmd(2'd2, 16'hff80, 16'h0200);
        run_cmd(2'd2, 16'h0300, 16'hfe00);
        run_cmd(2'd2, 16'hfd00, 16'hfc00);
        run_cmd(2'd2, 16'h4000, 16'h0400);
        run_cmd(2'd2, 16'h8000, 16'h0100);

        run_cmd(2'd3, 16'h0600, 16'h0200);
        run_cmd(2'd3, 16'h0100, 16'h0300);  // inexact
        run_cmd(2'd3, 16'hfa00, 16'h0200);
        run_cmd(2'd3, 16'h0600, 16'hfe00);
        run_cmd(2'd3, 16'hfa00, 16'hfe00);
        run_cmd(2'd3, 16'h8000, 16'h0200);
        run_cmd(2'd3, 16'h8000, 16'h0001);
        run_cmd(2'd3, 16'h7fff, 16'h0080);

        run_cmd(2'd3, 16'h0500, 16'h0000);
        run_cmd(2'd3, 16'h8000, 16'h0000);

        // strobe during a multiply is dropped
        send_cmd(2'd2, 16'h0180, 16'h0280);
        repeat (3) @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = fx_op_pkg::op_add;
        operand_a = 16'h1111;
        operand_b = 16'h2222;
        @(negedge clk);
        cmd_valid = 1'b0;
        wait_result();
        held = fx_model(2'd2, 16'h0180, 16'h0280);
        repeat (4) @(negedge clk);
        if (result !== held[15:0]) begin
            errors++;
            $display("error: result after done expected %h got %h", held[15:0], result);
        end

        for (int i = 0; i < 300; i++) begin
            rnd = $random(seed);
            ra  = $random(seed);
            rb  = $random(seed);
            run_cmd(rnd[1:0], pick_operand(ra), pick_operand(rb));
        end

        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== fx_unit_top.f ====
+incdir+.
fx_num_pkg.sv
fx_op_pkg.sv
fx_adder.sv
fx_multiplier.sv
fx_divider.sv
fx_control.sv
fx_unit_top.sv
tb_fx_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fx_unit \
    -f fx_unit_top.f -o tb_fx_unit || exit 1

out=$(./obj_dir/tb_fx_unit)
echo "$out"

echo "$out" | grep -qx "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
